/* logic/vram_pkg.sv */
package vram_pkg;

	localparam int ADDR_W      = 16; // client word address
	localparam int DATA_W      = 16;
	localparam int BANK_ADDR_W = 14; // offset inside one bank
	localparam int NUM_BANKS   = 4;
	localparam int BANK_SEL_W  = $clog2(NUM_BANKS);

	// grant state of one bank, values follow priority order
	typedef enum logic [2:0] {
		id_idle   = 3'd0,
		id_sprite = 3'd1,
		id_bg0    = 3'd2,
		id_bg1    = 3'd3,
		id_ov     = 3'd4,
		id_fl     = 3'd5,
		id_au     = 3'd6,
		id_cpu    = 3'd7
	} client_id_t;

	typedef struct packed {
		logic [BANK_SEL_W-1:0]  bank;   // top bits pick the bank
		logic [BANK_ADDR_W-1:0] offset;
	} vram_split_t;

	// one client address, seen whole or as bank plus offset
	typedef union packed {
		logic [ADDR_W-1:0] word;
		vram_split_t       split;
	} vram_addr_u;

endpackage

/* logic/bank_arbiter.sv */
`timescale 1ns/1ps

module bank_arbiter #(
	parameter logic [vram_pkg::BANK_SEL_W-1:0] BANK_SEL = '0
) (
	input  logic                          CLK,
	input  logic                          RSTb,

	input  vram_pkg::vram_addr_u          sprite_address,
	input  logic                          sprite_rvalid,
	input  vram_pkg::vram_addr_u          bg0_address,
	input  logic                          bg0_rvalid,
	input  vram_pkg::vram_addr_u          bg1_address,
	input  logic                          bg1_rvalid,
	input  vram_pkg::vram_addr_u          ov_address,
	input  logic                          ov_rvalid,
	input  vram_pkg::vram_addr_u          fl_address,
	input  logic [vram_pkg::DATA_W-1:0]   fl_data,
	input  logic                          fl_wvalid,
	input  vram_pkg::vram_addr_u          au_address,
	input  logic                          au_rvalid,
	input  vram_pkg::vram_addr_u          cpu_address,
	input  logic [vram_pkg::DATA_W-1:0]   cpu_data_in,
	input  logic                          cpu_wr,
	input  logic                          cpu_valid,

	output logic [vram_pkg::BANK_ADDR_W-1:0] ram_addr,
	output logic [vram_pkg::DATA_W-1:0]      ram_din,
	output logic                             ram_wr,
	output vram_pkg::client_id_t             grant
);

	import vram_pkg::*;

	client_id_t grant_next;

	logic hit_sp;
	logic hit_bg0;
	logic hit_bg1;
	logic hit_ov;
	logic hit_fl;
	logic hit_au;
	logic hit_cpu;

	// request aimed at this bank
	assign hit_sp  = sprite_rvalid && (sprite_address.split.bank == BANK_SEL);
	assign hit_bg0 = bg0_rvalid && (bg0_address.split.bank == BANK_SEL);
	assign hit_bg1 = bg1_rvalid && (bg1_address.split.bank == BANK_SEL);
	assign hit_ov  = ov_rvalid && (ov_address.split.bank == BANK_SEL);
	assign hit_fl  = fl_wvalid && (fl_address.split.bank == BANK_SEL);
	assign hit_au  = au_rvalid && (au_address.split.bank == BANK_SEL);
	assign hit_cpu = cpu_valid && (cpu_address.split.bank == BANK_SEL);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			grant <= id_idle;
		end else begin
			grant <= grant_next;
		end
	end

	always_comb begin
		grant_next = grant;
		ram_addr   = '0;
		ram_din    = '0;
		ram_wr     = 1'b0;
		case (grant)
			id_idle: begin // winner already drives the bank
				if (hit_sp) begin
					ram_addr   = sprite_address.split.offset;
					grant_next = id_sprite;
				end else if (hit_bg0) begin
					ram_addr   = bg0_address.split.offset;
					grant_next = id_bg0;
				end else if (hit_bg1) begin
					ram_addr   = bg1_address.split.offset;
					grant_next = id_bg1;
				end else if (hit_ov) begin
					ram_addr   = ov_address.split.offset;
					grant_next = id_ov;
				end else if (hit_fl) begin
					ram_addr   = fl_address.split.offset;
					ram_din    = fl_data;
					ram_wr     = 1'b1;
					grant_next = id_fl;
				end else if (hit_au) begin
					ram_addr   = au_address.split.offset;
					grant_next = id_au;
				end else if (hit_cpu) begin
					ram_addr   = cpu_address.split.offset;
					ram_din    = cpu_data_in;
					ram_wr     = cpu_wr;
					grant_next = id_cpu;
				end
			end
			id_sprite: begin
				ram_addr = sprite_address.split.offset;
				if (!sprite_rvalid) grant_next = id_idle;
			end
			id_bg0: begin
				ram_addr = bg0_address.split.offset;
				if (!bg0_rvalid) grant_next = id_idle;
			end
			id_bg1: begin
				ram_addr = bg1_address.split.offset;
				if (!bg1_rvalid) grant_next = id_idle;
			end
			id_ov: begin
				ram_addr = ov_address.split.offset;
				if (!ov_rvalid) grant_next = id_idle;
			end
			id_fl: begin
				ram_addr = fl_address.split.offset;
				ram_din  = fl_data;
				ram_wr   = fl_wvalid; // strobe drops with valid
				if (!fl_wvalid) grant_next = id_idle;
			end
			id_au: begin
				ram_addr = au_address.split.offset;
				if (!au_rvalid) grant_next = id_idle;
			end
			id_cpu: begin
				ram_addr = cpu_address.split.offset;
				ram_din  = cpu_data_in;
				ram_wr   = cpu_valid && cpu_wr;
				if (!cpu_valid) grant_next = id_idle;
			end
			default: grant_next = id_idle;
		endcase
	end

endmodule

/* logic/memory_arbiter.sv */
`timescale 1ns/1ps

module memory_arbiter (
	input  logic                          CLK,
	input  logic                          RSTb,

	input  vram_pkg::vram_addr_u          sprite_address,
	input  logic                          sprite_rvalid,
	output logic                          sprite_rready,
	output logic [vram_pkg::DATA_W-1:0]   sprite_data,

	input  vram_pkg::vram_addr_u          bg0_address,
	input  logic                          bg0_rvalid,
	output logic                          bg0_rready,
	output logic [vram_pkg::DATA_W-1:0]   bg0_data,

	input  vram_pkg::vram_addr_u          bg1_address,
	input  logic                          bg1_rvalid,
	output logic                          bg1_rready,
	output logic [vram_pkg::DATA_W-1:0]   bg1_data,

	input  vram_pkg::vram_addr_u          ov_address,
	input  logic                          ov_rvalid,
	output logic                          ov_rready,
	output logic [vram_pkg::DATA_W-1:0]   ov_data,

	input  vram_pkg::vram_addr_u          fl_address,
	input  logic [vram_pkg::DATA_W-1:0]   fl_data,
	input  logic                          fl_wvalid,
	output logic                          fl_wready,

	input  vram_pkg::vram_addr_u          au_address,
	input  logic                          au_rvalid,
	output logic                          au_rready,
	output logic [vram_pkg::DATA_W-1:0]   au_data,

	input  vram_pkg::vram_addr_u          cpu_address,
	input  logic [vram_pkg::DATA_W-1:0]   cpu_data_in,
	input  logic                          cpu_wr,
	input  logic                          cpu_valid,
	output logic                          cpu_ready,
	output logic [vram_pkg::DATA_W-1:0]   cpu_data,

	output logic [vram_pkg::BANK_ADDR_W-1:0] bank_addr [vram_pkg::NUM_BANKS],
	output logic [vram_pkg::DATA_W-1:0]      bank_din  [vram_pkg::NUM_BANKS],
	output logic                             bank_wr   [vram_pkg::NUM_BANKS],
	input  logic [vram_pkg::DATA_W-1:0]      bank_dout [vram_pkg::NUM_BANKS]
);

	import vram_pkg::*;

	client_id_t grant [NUM_BANKS];

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		bank_arbiter #(
			.BANK_SEL(BANK_SEL_W'(b))
		) u_arb (
			.CLK            (CLK),
			.RSTb           (RSTb),
			.sprite_address (sprite_address),
			.sprite_rvalid  (sprite_rvalid),
			.bg0_address    (bg0_address),
			.bg0_rvalid     (bg0_rvalid),
			.bg1_address    (bg1_address),
			.bg1_rvalid     (bg1_rvalid),
			.ov_address     (ov_address),
			.ov_rvalid      (ov_rvalid),
			.fl_address     (fl_address),
			.fl_data        (fl_data),
			.fl_wvalid      (fl_wvalid),
			.au_address     (au_address),
			.au_rvalid      (au_rvalid),
			.cpu_address    (cpu_address),
			.cpu_data_in    (cpu_data_in),
			.cpu_wr         (cpu_wr),
			.cpu_valid      (cpu_valid),
			.ram_addr       (bank_addr[b]),
			.ram_din        (bank_din[b]),
			.ram_wr         (bank_wr[b]),
			.grant          (grant[b])
		);
	end

	// a client hits one bank only, so at most one bank names it
	always_comb begin
		sprite_rready = 1'b0;
		sprite_data   = '0;
		bg0_rready    = 1'b0;
		bg0_data      = '0;
		bg1_rready    = 1'b0;
		bg1_data      = '0;
		ov_rready     = 1'b0;
		ov_data       = '0;
		fl_wready     = 1'b0;
		au_rready     = 1'b0;
		au_data       = '0;
		cpu_ready     = 1'b0;
		cpu_data      = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			case (grant[b])
				id_sprite: begin
					sprite_rready = 1'b1;
					sprite_data   = bank_dout[b];
				end
				id_bg0: begin
					bg0_rready = 1'b1;
					bg0_data   = bank_dout[b];
				end
				id_bg1: begin
					bg1_rready = 1'b1;
					bg1_data   = bank_dout[b];
				end
				id_ov: begin
					ov_rready = 1'b1;
					ov_data   = bank_dout[b];
				end
				id_fl: fl_wready = 1'b1; // write only
				id_au: begin
					au_rready = 1'b1;
					au_data   = bank_dout[b];
				end
				id_cpu: begin
					cpu_ready = 1'b1;
					cpu_data  = bank_dout[b];
				end
				default: ;
			endcase
		end
	end

endmodule

/* logic/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
	parameter int RAM_DEPTH_LOG2 = 14
) (
	input  logic                        CLK,
	input  logic [RAM_DEPTH_LOG2-1:0]   addr,
	input  logic [vram_pkg::DATA_W-1:0] din,
	input  logic                        wr,
	output logic [vram_pkg::DATA_W-1:0] dout
);

	import vram_pkg::*;

	localparam int RAM_WORDS = 2 ** RAM_DEPTH_LOG2;

	logic [DATA_W-1:0] mem [RAM_WORDS];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= din;
		end
	end

	// one cycle read latency, old word on a same-address write
	always_ff @(posedge CLK) begin
		dout <= mem[addr];
	end

endmodule

/* logic/video_memory.sv */
`timescale 1ns/1ps

module video_memory #(
	parameter int RAM_DEPTH_LOG2 = vram_pkg::BANK_ADDR_W
) (
	input  logic                          CLK,
	input  logic                          RSTb,

	input  vram_pkg::vram_addr_u          sprite_address,
	input  logic                          sprite_rvalid,
	output logic                          sprite_rready,
	output logic [vram_pkg::DATA_W-1:0]   sprite_data,

	input  vram_pkg::vram_addr_u          bg0_address,
	input  logic                          bg0_rvalid,
	output logic                          bg0_rready,
	output logic [vram_pkg::DATA_W-1:0]   bg0_data,

	input  vram_pkg::vram_addr_u          bg1_address,
	input  logic                          bg1_rvalid,
	output logic                          bg1_rready,
	output logic [vram_pkg::DATA_W-1:0]   bg1_data,

	input  vram_pkg::vram_addr_u          ov_address,
	input  logic                          ov_rvalid,
	output logic                          ov_rready,
	output logic [vram_pkg::DATA_W-1:0]   ov_data,

	input  vram_pkg::vram_addr_u          fl_address,
	input  logic [vram_pkg::DATA_W-1:0]   fl_data,
	input  logic                          fl_wvalid,
	output logic                          fl_wready,

	input  vram_pkg::vram_addr_u          au_address,
	input  logic                          au_rvalid,
	output logic                          au_rready,
	output logic [vram_pkg::DATA_W-1:0]   au_data,

	input  vram_pkg::vram_addr_u          cpu_address,
	input  logic [vram_pkg::DATA_W-1:0]   cpu_data_in,
	input  logic                          cpu_wr,
	input  logic                          cpu_valid,
	output logic                          cpu_ready,
	output logic [vram_pkg::DATA_W-1:0]   cpu_data
);

	import vram_pkg::*;

	logic [RAM_DEPTH_LOG2-1:0] bank_addr [NUM_BANKS];
	logic [DATA_W-1:0]         bank_din  [NUM_BANKS];
	logic                      bank_wr   [NUM_BANKS];
	logic [DATA_W-1:0]         bank_dout [NUM_BANKS];

	memory_arbiter u_arbiter (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.sprite_address (sprite_address),
		.sprite_rvalid  (sprite_rvalid),
		.sprite_rready  (sprite_rready),
		.sprite_data    (sprite_data),
		.bg0_address    (bg0_address),
		.bg0_rvalid     (bg0_rvalid),
		.bg0_rready     (bg0_rready),
		.bg0_data       (bg0_data),
		.bg1_address    (bg1_address),
		.bg1_rvalid     (bg1_rvalid),
		.bg1_rready     (bg1_rready),
		.bg1_data       (bg1_data),
		.ov_address     (ov_address),
		.ov_rvalid      (ov_rvalid),
		.ov_rready      (ov_rready),
		.ov_data        (ov_data),
		.fl_address     (fl_address),
		.fl_data        (fl_data),
		.fl_wvalid      (fl_wvalid),
		.fl_wready      (fl_wready),
		.au_address     (au_address),
		.au_rvalid      (au_rvalid),
		.au_rready      (au_rready),
		.au_data        (au_data),
		.cpu_address    (cpu_address),
		.cpu_data_in    (cpu_data_in),
		.cpu_wr         (cpu_wr),
		.cpu_valid      (cpu_valid),
		.cpu_ready      (cpu_ready),
		.cpu_data       (cpu_data),
		.bank_addr      (bank_addr),
		.bank_din       (bank_din),
		.bank_wr        (bank_wr),
		.bank_dout      (bank_dout)
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_ram
		bank_ram #(
			.RAM_DEPTH_LOG2(RAM_DEPTH_LOG2)
		) u_ram (
			.CLK  (CLK),
			.addr (bank_addr[b]),
			.din  (bank_din[b]),
			.wr   (bank_wr[b]),
			.dout (bank_dout[b])
		);
	end

endmodule

/* verification/tb_client_tasks.svh */
logic [DATA_W-1:0] shadow [2**ADDR_W]; // every word the testbench wrote
bit                known  [2**ADDR_W];
vram_addr_u        written_q [$];
vram_addr_u        job_addr [NCL];
logic [DATA_W-1:0] job_data [NCL];
logic              job_wr   [NCL];
int                job_lat  [NCL];
int                grant_order [$];
int                cmp_checks;
int                cmp_errors;

function automatic logic [DATA_W-1:0] expected_read(input vram_addr_u a);
	return shadow[a.word];
endfunction

// index order is the priority order so the lowest index wins
function automatic int expected_winner(input logic [NCL-1:0] req);
	for (int c = 0; c < NCL; c++) begin
		if (req[c]) return c;
	end
	return -1;
endfunction

task automatic access(input int c, input vram_addr_u a, input logic [DATA_W-1:0] d,
		input logic wr, output int lat);
	int n;
	@(negedge CLK);
	addr[c]  = a;
	wdata[c] = d;
	if (c == CPU) cpu_wr = wr;
	valid[c] = 1'b1;
	n = 0;
	do begin
		@(negedge CLK);
		n++;
	end while (!ready[c] && n < WAIT_LIMIT);
	lat      = n;
	valid[c] = 1'b0; // one ready cycle is enough
	checks++;
	assert (ready[c]) else begin
		$display("at %0t the %s request to address %h was never granted",
			$time, names[c], a.word);
		errors++;
	end
	if (ready[c] && wr) begin
		shadow[a.word] = d;
		known[a.word]  = 1'b1;
		written_q.push_back(a);
	end
endtask

task automatic client_job(input int c);
	int lat;
	access(c, job_addr[c], job_data[c], job_wr[c], lat);
	job_lat[c] = lat;
	grant_order.push_back(c);
endtask

task automatic run_group(input logic [NCL-1:0] mask);
	grant_order.delete();
	fork
		if (mask[0]) client_job(0);
		if (mask[1]) client_job(1);
		if (mask[2]) client_job(2);
		if (mask[3]) client_job(3);
		if (mask[4]) client_job(4);
		if (mask[5]) client_job(5);
		if (mask[6]) client_job(6);
	join
endtask

// data in a ready cycle belongs to the address seen at the edge before
initial begin : compare_reads
	vram_addr_u seen [NCL];
	logic       seen_wr;
	cmp_checks = 0;
	cmp_errors = 0;
	forever begin
		@(posedge CLK);
		seen    = addr;
		seen_wr = cpu_wr;
		@(negedge CLK);
		for (int c = 0; c < NCL; c++) begin
			if (ready[c] && c != FL && !(c == CPU && seen_wr) && known[seen[c].word]) begin
				cmp_checks++;
				assert (rdata[c] == expected_read(seen[c])) else begin
					$display("ERROR %0t: %s_data got %h expected %h", $time, names[c],
						rdata[c], expected_read(seen[c]));
					cmp_errors++;
				end
			end
		end
	end
end

/* verification/tb_video_memory.sv */
`timescale 1ns/1ps

module tb_video_memory;

	import vram_pkg::*;

	localparam int NCL        = 7; // sprite bg0 bg1 ov fl au cpu
	localparam int FL         = 4;
	localparam int CPU        = 6;
	localparam int WAIT_LIMIT = 100;

	logic              CLK;
	logic              RSTb;
	vram_addr_u        addr  [NCL];
	logic [DATA_W-1:0] wdata [NCL];
	logic              valid [NCL];
	logic              cpu_wr;
	logic              ready [NCL];
	logic [DATA_W-1:0] rdata [NCL];

	string names [NCL] = '{"sprite", "bg0", "bg1", "ov", "fl", "au", "cpu"};
	string ready_names [NCL] = '{"sprite_rready", "bg0_rready", "bg1_rready", "ov_rready",
		"fl_wready", "au_rready", "cpu_ready"};
	int errors;
	int checks;
	int test_base;

	`include "tb_client_tasks.svh"

	video_memory #(.RAM_DEPTH_LOG2(BANK_ADDR_W)) DUT (
		.CLK(CLK), .RSTb(RSTb),
		.sprite_address(addr[0]), .sprite_rvalid(valid[0]),
		.sprite_rready(ready[0]), .sprite_data(rdata[0]),
		.bg0_address(addr[1]), .bg0_rvalid(valid[1]),
		.bg0_rready(ready[1]), .bg0_data(rdata[1]),
		.bg1_address(addr[2]), .bg1_rvalid(valid[2]),
		.bg1_rready(ready[2]), .bg1_data(rdata[2]),
		.ov_address(addr[3]), .ov_rvalid(valid[3]),
		.ov_rready(ready[3]), .ov_data(rdata[3]),
		.fl_address(addr[4]), .fl_data(wdata[4]),
		.fl_wvalid(valid[4]), .fl_wready(ready[4]),
		.au_address(addr[5]), .au_rvalid(valid[5]),
		.au_rready(ready[5]), .au_data(rdata[5]),
		.cpu_address(addr[6]), .cpu_data_in(wdata[6]), .cpu_wr(cpu_wr),
		.cpu_valid(valid[6]), .cpu_ready(ready[6]), .cpu_data(rdata[6])
	);

	assign rdata[FL] = '0; // flash has no read port

	initial begin : clock_gen
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	function automatic vram_addr_u make_addr(input int bank, input int offset);
		vram_addr_u a;
		a.split.bank   = BANK_SEL_W'(bank);
		a.split.offset = BANK_ADDR_W'(offset);
		return a;
	endfunction

	// reads only hit words already written
	function automatic void pick_job(input int c);
		job_wr[c]   = (c == FL) || (c == CPU && $urandom_range(1) == 1);
		job_data[c] = DATA_W'($urandom);
		if (job_wr[c]) begin
			job_addr[c] = make_addr($urandom_range(3), $urandom_range(2**BANK_ADDR_W - 1));
		end else begin
			job_addr[c] = written_q[$urandom_range(written_q.size() - 1)];
		end
	endfunction

	task automatic check_latency(input int c);
		checks++;
		assert (job_lat[c] == 1) else begin
			$display("ERROR %0t: %s latency got %0d expected 1",
				$time, ready_names[c], job_lat[c]);
			errors++;
		end
	endtask

	task automatic contend(input logic [NCL-1:0] mask, input int bank);
		logic [NCL-1:0] left;
		int want;
		for (int c = 0; c < NCL; c++) begin
			job_addr[c] = written_q[bank]; // first flash words sit in banks 0 to 3
			job_data[c] = DATA_W'($urandom);
			job_wr[c]   = (c == FL);
		end
		run_group(mask);
		check_latency(expected_winner(mask));
		left = mask;
		for (int k = 0; k < grant_order.size(); k++) begin
			want = expected_winner(left);
			checks++;
			assert (grant_order[k] == want) else begin
				$display("ERROR %0t: grant %0d got %s expected %s", $time, k,
					names[grant_order[k]], names[want]);
				errors++;
			end
			left[want] = 1'b0;
		end
	endtask

	task automatic parallel(input logic [NCL-1:0] mask);
		int k;
		k = 0;
		for (int c = 0; c < NCL; c++) begin
			job_wr[c]   = (c == FL);
			job_data[c] = DATA_W'($urandom);
			if (mask[c]) begin
				job_addr[c] = written_q[k];
				k++;
			end
		end
		run_group(mask);
		for (int c = 0; c < NCL; c++) begin
			if (mask[c]) check_latency(c);
		end
	endtask

	task automatic end_test(input int n, input string what);
		$display("test %0d %s: %0d errors", n, what, errors + cmp_errors - test_base);
		test_base = errors + cmp_errors;
	endtask

	initial begin : run_tests
		logic [NCL-1:0] mask;
		int lat;
		int rc;
		int nflash;
		void'($urandom(33315));
		errors    = 0;
		checks    = 0;
		test_base = 0;
		RSTb      = 1'b0;
		cpu_wr    = 1'b0;
		for (int c = 0; c < NCL; c++) begin
			addr[c]  = '0;
			wdata[c] = '0;
			valid[c] = 1'b0;
		end

		for (int i = 0; i < 20; i++) begin
			@(negedge CLK);
			if (i == 15) RSTb = 1'b1;
			for (int c = 0; c < NCL; c++) begin
				checks++;
				assert (ready[c] == 1'b0) else begin
					$display("ERROR %0t: %s got %b expected 0",
						$time, ready_names[c], ready[c]);
					errors++;
				end
			end
		end
		end_test(1, "reset");

		for (int i = 0; i < 16; i++) begin
			access(FL, make_addr(i % 4, $urandom_range(2**BANK_ADDR_W - 1)),
				DATA_W'($urandom), 1'b1, lat);
		end
		nflash = written_q.size();
		for (int i = 0; i < nflash; i++) begin
			rc = (i % 5 == 4) ? 5 : i % 5; // readers only
			access(rc, written_q[i], '0, 1'b0, lat);
		end
		end_test(2, "flash load and readback");

		for (int i = 0; i < 12; i++) begin
			access(CPU, make_addr($urandom_range(3), $urandom_range(2**BANK_ADDR_W - 1)),
				DATA_W'($urandom), 1'b1, lat);
		end
		for (int i = nflash; i < written_q.size(); i++) begin
			access(CPU, written_q[i], '0, 1'b0, lat);
		end
		for (int i = 0; i < 4; i++) begin
			access(CPU, written_q[i], '0, 1'b0, lat);
		end
		end_test(3, "cpu access");

		contend(7'b1000101, 1); // sprite bg1 cpu
		contend(7'b0110010, 2); // bg0 fl au
		contend(7'b1001000, 3);
		end_test(4, "priority");

		parallel(7'b0100111);
		parallel(7'b1111000);
		end_test(5, "bank parallelism");

		for (int r = 0; r < 300; r++) begin
			mask = NCL'($urandom_range(1, 2**NCL - 1));
			for (int c = 0; c < NCL; c++) pick_job(c);
			run_group(mask);
		end
		end_test(6, "random traffic");

		$display("checks %0d, errors %0d", checks + cmp_checks, errors + cmp_errors);
		if (errors + cmp_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+verification
logic/vram_pkg.sv
logic/bank_arbiter.sv
logic/memory_arbiter.sv
logic/bank_ram.sv
logic/video_memory.sv
verification/tb_video_memory.sv

/* Makefile */
# Verilator flow for the video memory testbench
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module tb_video_memory

sim:
	verilator --binary --timing --assert -j 0 -f sources.f \
		--top-module tb_video_memory -o tb_video_memory
	./obj_dir/tb_video_memory | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
